/* source/procPkg.sv */
// widths, memory depths, opcodes, instruction formats and ALU op encoding
package procPkg;

   localparam int dataWidth    = 16;
   localparam int regAddrWidth = 3;
   localparam int memAddrWidth = 8;
   localparam int memDepth     = 256;

   // opcode sits in bits 15:12, codes 9 to 14 are illegal
   localparam logic [3:0] opAdd  = 4'd0;
   localparam logic [3:0] opSub  = 4'd1;
   localparam logic [3:0] opAnd  = 4'd2;
   localparam logic [3:0] opXor  = 4'd3;
   localparam logic [3:0] opAddi = 4'd4;
   localparam logic [3:0] opLd   = 4'd5;
   localparam logic [3:0] opSt   = 4'd6;
   localparam logic [3:0] opBeqz = 4'd7;
   localparam logic [3:0] opBnez = 4'd8;
   localparam logic [3:0] opHalt = 4'd15;

   // register format
   typedef struct packed {
      logic [3:0]              opcode;
      logic [regAddrWidth-1:0] rd;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [2:0]              unused;
   } instrR;

   // immediate format
   typedef struct packed {
      logic [3:0]              opcode;
      logic [regAddrWidth-1:0] rd;
      logic [regAddrWidth-1:0] rs;
      logic signed [5:0]       imm;
   } instrI;

   // one instruction word, read through either format
   typedef union packed {
      instrR rFmt;
      instrI iFmt;
   } instrWord;

   // encodings follow opAdd..opXor so opcode[1:0] maps straight across
   typedef enum logic [1:0] {
      aluAdd = 2'd0,
      aluSub = 2'd1,
      aluAnd = 2'd2,
      aluXor = 2'd3
   } aluOpT;

endpackage

/* source/fetch.sv */
// program counter, instruction memory with its load port and the F/D register
`timescale 1ns/1ps
`default_nettype none
module fetch (
   // Inputs
   input  logic                             clk,
   input  logic                             rstN,
   input  logic                             run,
   input  logic                             imemWe,
   input  logic [procPkg::memAddrWidth-1:0] imemAddr,
   input  logic [procPkg::dataWidth-1:0]    imemData,
   input  logic                             stall,
   input  logic                             redirect,
   input  logic [procPkg::memAddrWidth-1:0] redirectPc,
   input  logic                             haltSeen,
   // Outputs
   output procPkg::instrWord                instruction,
   output logic [procPkg::memAddrWidth-1:0] nextPc,
   output logic                             fdValid
);
   import procPkg::*;

   logic [dataWidth-1:0]    imem [memDepth];
   logic [memAddrWidth-1:0] pc;
   logic                    issue;

   assign issue = run && !haltSeen;

   // program load, one word per strobe
   always_ff @(posedge clk) begin
      if (imemWe) begin
         imem[imemAddr] <= imemData;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc      <= '0;
         fdValid <= 1'b0;
      end else if (redirect) begin
         // taken branch, the word in F/D is on the wrong path
         pc      <= redirectPc;
         fdValid <= 1'b0;
      end else if (!stall) begin
         fdValid <= issue;
         if (issue) begin
            pc <= pc + 1'b1;
         end
      end
   end

   // F/D payload holds during a stall
   always_ff @(posedge clk) begin
      if (!redirect && !stall) begin
         instruction <= imem[pc];
         nextPc      <= pc + 1'b1;
      end
   end

endmodule
`default_nettype wire

/* source/decode.sv */
// instruction decode, register file with write bypass, load-use stall, HALT/err and D/X register
`timescale 1ns/1ps
`default_nettype none
module decode (
   // Inputs
   input  logic                             clk,
   input  logic                             rstN,
   input  procPkg::instrWord                instruction,
   input  logic [procPkg::memAddrWidth-1:0] nextPc,
   input  logic                             fdValid,
   input  logic                             redirect,
   input  logic                             wbEn,
   input  logic [procPkg::regAddrWidth-1:0] wbReg,
   input  logic [procPkg::dataWidth-1:0]    wbData,
   input  logic                             xLoad,
   input  logic [procPkg::regAddrWidth-1:0] xDestReg,
   // Outputs
   output logic                             stall,
   output logic                             haltSeen,
   output logic                             err,
   output logic                             dxValid,
   output procPkg::aluOpT                   aluOp,
   output logic                             useImm,
   output logic                             memRead,
   output logic                             memWrite,
   output logic                             branchZero,
   output logic                             branchNonZero,
   output logic                             isHalt,
   output logic [procPkg::regAddrWidth-1:0] rsReg,
   output logic [procPkg::regAddrWidth-1:0] rtReg,
   output logic [procPkg::dataWidth-1:0]    rsVal,
   output logic [procPkg::dataWidth-1:0]    rtVal,
   output logic [procPkg::dataWidth-1:0]    imm,
   output logic [procPkg::memAddrWidth-1:0] dNextPc,
   output logic                             wbEnOut,
   output logic [procPkg::regAddrWidth-1:0] wbRegOut
);
   import procPkg::*;

   logic [dataWidth-1:0]    regs [2**regAddrWidth];
   logic [3:0]              opcode;
   logic [regAddrWidth-1:0] rd;
   logic [regAddrWidth-1:0] rs;
   logic [regAddrWidth-1:0] rtSrc;
   logic isAluR, isAddi, isLoad, isStore, isBeqz, isBnez, isHaltOp, illegal;
   logic usesRs, usesRt, writesRd;
   logic haltNow, haltLatch, issue;

   // r0 reads zero, a same-cycle writeback is bypassed
   function automatic logic [dataWidth-1:0] readReg(input logic [regAddrWidth-1:0] r);
      if (r == '0) begin
         return '0;
      end else if (wbEn && wbReg == r) begin
         return wbData;
      end
      return regs[r];
   endfunction

   assign opcode = instruction.rFmt.opcode;
   assign rd     = instruction.rFmt.rd;
   assign rs     = instruction.rFmt.rs;
   // ST stores rd, so it goes down the rt path
   assign rtSrc  = isStore ? rd : instruction.rFmt.rt;

   always_comb begin
      isAluR   = 1'b0;
      isAddi   = 1'b0;
      isLoad   = 1'b0;
      isStore  = 1'b0;
      isBeqz   = 1'b0;
      isBnez   = 1'b0;
      isHaltOp = 1'b0;
      illegal  = 1'b0;
      case (opcode)
         opAdd, opSub, opAnd, opXor: isAluR = 1'b1;
         opAddi:  isAddi   = 1'b1;
         opLd:    isLoad   = 1'b1;
         opSt:    isStore  = 1'b1;
         opBeqz:  isBeqz   = 1'b1;
         opBnez:  isBnez   = 1'b1;
         opHalt:  isHaltOp = 1'b1;
         default: illegal  = 1'b1;
      endcase
   end

   assign usesRs   = isAluR || isAddi || isLoad || isStore || isBeqz || isBnez;
   assign usesRt   = isAluR || isStore;
   assign writesRd = isAluR || isAddi || isLoad;

   // load in execute feeding this instruction costs one bubble
   assign stall = fdValid && xLoad && xDestReg != '0 &&
                  ((usesRs && rs == xDestReg) || (usesRt && rtSrc == xDestReg));

   assign haltNow  = fdValid && !redirect && (isHaltOp || illegal);
   assign haltSeen = haltLatch || haltNow;
   assign issue    = fdValid && !stall && !redirect;

   always_ff @(posedge clk) begin
      if (wbEn) begin
         regs[wbReg] <= wbData;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         haltLatch     <= 1'b0;
         err           <= 1'b0;
         dxValid       <= 1'b0;
         memRead       <= 1'b0;
         memWrite      <= 1'b0;
         branchZero    <= 1'b0;
         branchNonZero <= 1'b0;
         isHalt        <= 1'b0;
         wbEnOut       <= 1'b0;
      end else begin
         haltLatch     <= haltLatch || haltNow;
         err           <= err || (haltNow && illegal);
         dxValid       <= issue;
         memRead       <= issue && isLoad;
         memWrite      <= issue && isStore;
         branchZero    <= issue && isBeqz;
         branchNonZero <= issue && isBnez;
         isHalt        <= issue && (isHaltOp || illegal);
         // r0 writes never leave decode
         wbEnOut       <= issue && writesRd && rd != '0;
      end
   end

   always_ff @(posedge clk) begin
      aluOp    <= isAluR ? aluOpT'(opcode[1:0]) : aluAdd;
      useImm   <= !isAluR;
      rsReg    <= rs;
      rtReg    <= rtSrc;
      rsVal    <= readReg(rs);
      rtVal    <= readReg(rtSrc);
      // sign extends, the field is signed
      imm      <= dataWidth'(instruction.iFmt.imm);
      dNextPc  <= nextPc;
      wbRegOut <= rd;
   end

endmodule
`default_nettype wire

/* source/execute.sv */
// operand forwarding, ALU, branch resolution and the X/M register
`timescale 1ns/1ps
`default_nettype none
module execute (
   // Inputs
   input  logic                             clk,
   input  logic                             rstN,
   input  logic                             dxValid,
   input  procPkg::aluOpT                   aluOp,
   input  logic                             useImm,
   input  logic                             dMemRead,
   input  logic                             dMemWrite,
   input  logic                             branchZero,
   input  logic                             branchNonZero,
   input  logic                             isHalt,
   input  logic [procPkg::regAddrWidth-1:0] rsReg,
   input  logic [procPkg::regAddrWidth-1:0] rtReg,
   input  logic [procPkg::dataWidth-1:0]    rsVal,
   input  logic [procPkg::dataWidth-1:0]    rtVal,
   input  logic [procPkg::dataWidth-1:0]    imm,
   input  logic [procPkg::memAddrWidth-1:0] dNextPc,
   input  logic                             wbEnOut,
   input  logic [procPkg::regAddrWidth-1:0] wbRegOut,
   input  logic                             mWbEn,
   input  logic [procPkg::regAddrWidth-1:0] mWbReg,
   input  logic [procPkg::dataWidth-1:0]    mResult,
   input  logic                             wbEn,
   input  logic [procPkg::regAddrWidth-1:0] wbReg,
   input  logic [procPkg::dataWidth-1:0]    wbData,
   // Outputs
   output logic                             redirect,
   output logic [procPkg::memAddrWidth-1:0] redirectPc,
   output logic                             xLoad,
   output logic [procPkg::regAddrWidth-1:0] xDestReg,
   output logic                             xmValid,
   output logic [procPkg::dataWidth-1:0]    aluResult,
   output logic [procPkg::dataWidth-1:0]    storeData,
   output logic                             memRead,
   output logic                             memWrite,
   output logic                             wbEnX,
   output logic [procPkg::regAddrWidth-1:0] wbRegX,
   output logic                             isHaltX
);
   import procPkg::*;

   logic [dataWidth-1:0] opA;
   logic [dataWidth-1:0] opB;
   logic [dataWidth-1:0] aluB;
   logic [dataWidth-1:0] aluOut;

   // youngest producer wins, memory stage before writeback
   function automatic logic [dataWidth-1:0] pickOperand(
      input logic [regAddrWidth-1:0] r,
      input logic [dataWidth-1:0]    regVal
   );
      if (r == '0) begin
         return regVal;
      end else if (mWbEn && mWbReg == r) begin
         return mResult;
      end else if (wbEn && wbReg == r) begin
         return wbData;
      end
      return regVal;
   endfunction

   assign opA  = pickOperand(rsReg, rsVal);
   assign opB  = pickOperand(rtReg, rtVal);
   assign aluB = useImm ? imm : opB;

   // also forms the LD/ST address
   always_comb begin
      case (aluOp)
         aluSub:  aluOut = opA - aluB;
         aluAnd:  aluOut = opA & aluB;
         aluXor:  aluOut = opA ^ aluB;
         default: aluOut = opA + aluB;
      endcase
   end

   // branch flags only arrive set for a valid slot
   assign redirect   = (branchZero && opA == '0) || (branchNonZero && opA != '0);
   assign redirectPc = dNextPc + imm[memAddrWidth-1:0];

   // load-use check in decode
   assign xLoad    = dMemRead;
   assign xDestReg = wbRegOut;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         xmValid  <= 1'b0;
         memRead  <= 1'b0;
         memWrite <= 1'b0;
         wbEnX    <= 1'b0;
         isHaltX  <= 1'b0;
      end else begin
         xmValid  <= dxValid;
         memRead  <= dMemRead;
         memWrite <= dMemWrite;
         wbEnX    <= wbEnOut;
         isHaltX  <= isHalt;
      end
   end

   always_ff @(posedge clk) begin
      aluResult <= aluOut;
      storeData <= opB;
      wbRegX    <= wbRegOut;
   end

endmodule
`default_nettype wire

/* source/memory.sv */
// data memory, store strobe, writeback select in the M/W register and the halted flag
`timescale 1ns/1ps
`default_nettype none
module memory (
   // Inputs
   input  logic                             clk,
   input  logic                             rstN,
   input  logic                             xmValid,
   input  logic [procPkg::dataWidth-1:0]    aluResult,
   input  logic [procPkg::dataWidth-1:0]    storeData,
   input  logic                             memRead,
   input  logic                             memWrite,
   input  logic                             wbEnX,
   input  logic [procPkg::regAddrWidth-1:0] wbRegX,
   input  logic                             isHaltX,
   // Outputs
   output logic                             mWbEn,
   output logic [procPkg::regAddrWidth-1:0] mWbReg,
   output logic [procPkg::dataWidth-1:0]    mResult,
   output logic                             wbEn,
   output logic [procPkg::regAddrWidth-1:0] wbReg,
   output logic [procPkg::dataWidth-1:0]    wbData,
   output logic                             storeValid,
   output logic [procPkg::memAddrWidth-1:0] storeAddr,
   output logic [procPkg::dataWidth-1:0]    storeDataOut,
   output logic                             halted
);
   import procPkg::*;

   logic [dataWidth-1:0]    dmem [memDepth];
   logic [memAddrWidth-1:0] addr;

   // word addressed, upper address bits ignored
   assign addr = aluResult[memAddrWidth-1:0];

   // forwarding taps into execute
   assign mWbEn   = wbEnX;
   assign mWbReg  = wbRegX;
   assign mResult = aluResult;

   assign storeValid   = memWrite;
   assign storeAddr    = addr;
   assign storeDataOut = storeData;

   always_ff @(posedge clk) begin
      if (memWrite) begin
         dmem[addr] <= storeData;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         wbEn   <= 1'b0;
         halted <= 1'b0;
      end else begin
         wbEn   <= wbEnX;
         // HALT now in writeback, sticky until reset
         halted <= halted || (xmValid && isHaltX);
      end
   end

   always_ff @(posedge clk) begin
      wbReg  <= wbRegX;
      wbData <= memRead ? dmem[addr] : aluResult;
   end

endmodule
`default_nettype wire

/* source/proc.sv */
// processor top level: fetch, decode, execute and memory stages and their wiring
`timescale 1ns/1ps
`default_nettype none
module proc (
   // Inputs
   input  logic                             clk,
   input  logic                             rstN,
   input  logic                             run,
   input  logic                             imemWe,
   input  logic [procPkg::memAddrWidth-1:0] imemAddr,
   input  logic [procPkg::dataWidth-1:0]    imemData,
   // Outputs
   output logic                             retireValid,
   output logic [procPkg::regAddrWidth-1:0] retireReg,
   output logic [procPkg::dataWidth-1:0]    retireData,
   output logic                             storeValid,
   output logic [procPkg::memAddrWidth-1:0] storeAddr,
   output logic [procPkg::dataWidth-1:0]    storeData,
   output logic                             halted,
   output logic                             err
);
   import procPkg::*;

   instrWord                instructionF;
   logic [memAddrWidth-1:0] nextPcF, nextPcD, redirectPc;
   logic                    fdValid, stall, haltSeen, redirect;
   logic                    dxValid, useImmD, memReadD, memWriteD;
   logic                    branchZeroD, branchNonZeroD, isHaltD, wbEnD;
   aluOpT                   aluOpD;
   logic [regAddrWidth-1:0] rsRegD, rtRegD, wbRegD, xDestReg;
   logic [dataWidth-1:0]    rsValD, rtValD, immD;
   logic                    xLoad, xmValid, memReadM, memWriteM, wbEnM, isHaltM;
   logic [dataWidth-1:0]    aluResultM, storeDataM, mResult, wbDataW;
   logic [regAddrWidth-1:0] wbRegM, mWbReg, wbRegW;
   logic                    mWbEn, wbEnW;

   fetch fetchStage (
      .clk(clk), .rstN(rstN), .run(run),
      .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
      .stall(stall), .redirect(redirect), .redirectPc(redirectPc), .haltSeen(haltSeen),
      .instruction(instructionF), .nextPc(nextPcF), .fdValid(fdValid)
   );

   decode decodeStage (
      .clk(clk), .rstN(rstN), .instruction(instructionF), .nextPc(nextPcF),
      .fdValid(fdValid), .redirect(redirect),
      .wbEn(wbEnW), .wbReg(wbRegW), .wbData(wbDataW),
      .xLoad(xLoad), .xDestReg(xDestReg),
      .stall(stall), .haltSeen(haltSeen), .err(err), .dxValid(dxValid),
      .aluOp(aluOpD), .useImm(useImmD), .memRead(memReadD), .memWrite(memWriteD),
      .branchZero(branchZeroD), .branchNonZero(branchNonZeroD), .isHalt(isHaltD),
      .rsReg(rsRegD), .rtReg(rtRegD), .rsVal(rsValD), .rtVal(rtValD),
      .imm(immD), .dNextPc(nextPcD), .wbEnOut(wbEnD), .wbRegOut(wbRegD)
   );

   execute executeStage (
      .clk(clk), .rstN(rstN), .dxValid(dxValid),
      .aluOp(aluOpD), .useImm(useImmD), .dMemRead(memReadD), .dMemWrite(memWriteD),
      .branchZero(branchZeroD), .branchNonZero(branchNonZeroD), .isHalt(isHaltD),
      .rsReg(rsRegD), .rtReg(rtRegD), .rsVal(rsValD), .rtVal(rtValD),
      .imm(immD), .dNextPc(nextPcD), .wbEnOut(wbEnD), .wbRegOut(wbRegD),
      .mWbEn(mWbEn), .mWbReg(mWbReg), .mResult(mResult),
      .wbEn(wbEnW), .wbReg(wbRegW), .wbData(wbDataW),
      .redirect(redirect), .redirectPc(redirectPc), .xLoad(xLoad), .xDestReg(xDestReg),
      .xmValid(xmValid), .aluResult(aluResultM), .storeData(storeDataM),
      .memRead(memReadM), .memWrite(memWriteM),
      .wbEnX(wbEnM), .wbRegX(wbRegM), .isHaltX(isHaltM)
   );

   memory memoryStage (
      .clk(clk), .rstN(rstN), .xmValid(xmValid),
      .aluResult(aluResultM), .storeData(storeDataM),
      .memRead(memReadM), .memWrite(memWriteM),
      .wbEnX(wbEnM), .wbRegX(wbRegM), .isHaltX(isHaltM),
      .mWbEn(mWbEn), .mWbReg(mWbReg), .mResult(mResult),
      .wbEn(wbEnW), .wbReg(wbRegW), .wbData(wbDataW),
      .storeValid(storeValid), .storeAddr(storeAddr), .storeDataOut(storeData),
      .halted(halted)
   );

   // r0 writes are already dropped in decode
   assign retireValid = wbEnW;
   assign retireReg   = wbRegW;
   assign retireData  = wbDataW;

endmodule
`default_nettype wire

/* verif/procChecker.sv */
// instruction-set model of the processor, in-order retire and store comparison, test counts
`timescale 1ns/1ps
module procChecker (
   input  logic                             clk,
   input  logic                             rstN,
   input  logic                             run,
   input  logic                             imemWe,
   input  logic [procPkg::memAddrWidth-1:0] imemAddr,
   input  logic [procPkg::dataWidth-1:0]    imemData,
   input  logic                             retireValid,
   input  logic [procPkg::regAddrWidth-1:0] retireReg,
   input  logic [procPkg::dataWidth-1:0]    retireData,
   input  logic                             storeValid,
   input  logic [procPkg::memAddrWidth-1:0] storeAddr,
   input  logic [procPkg::dataWidth-1:0]    storeData,
   input  logic                             halted,
   input  logic                             err,
   input  logic                             testEnd,
   input  logic                             testAbort,
   input  int                               testNum,
   output int                               testsRun,
   output int                               testsFailed
);
   import procPkg::*;

   logic [dataWidth-1:0] prog [memDepth];
   logic [18:0]          expRetire [$];
   logic [23:0]          expStore [$];
   logic                 expErr;
   logic                 runPrev;
   int                   testErrors;

   // runs the loaded program to its HALT or illegal opcode
   task automatic buildModel();
      logic [dataWidth-1:0]    regs [8];
      logic [dataWidth-1:0]    dmem [memDepth];
      logic [dataWidth-1:0]    w, a, immv, v;
      logic [memAddrWidth-1:0] pc, addr;
      logic [3:0]              op;
      logic [2:0]              rd;
      logic                    wr, done;
      int                      steps;
      for (int i = 0; i < 8; i++) begin
         regs[i] = '0;
      end
      pc = '0;
      done = 1'b0;
      expErr = 1'b0;
      expRetire.delete();
      expStore.delete();
      for (steps = 0; steps < 2000 && !done; steps++) begin
         w = prog[pc];
         op = w[15:12];
         rd = w[11:9];
         a = regs[w[8:6]];
         immv = {{10{w[5]}}, w[5:0]};
         addr = a + immv;
         pc = pc + 1'b1;
         wr = 1'b1;
         case (op)
            opAdd:  v = a + regs[w[5:3]];
            opSub:  v = a - regs[w[5:3]];
            opAnd:  v = a & regs[w[5:3]];
            opXor:  v = a ^ regs[w[5:3]];
            opAddi: v = a + immv;
            opLd:   v = dmem[addr];
            default: wr = 1'b0;
         endcase
         if (op == opSt) begin
            dmem[addr] = regs[rd];
            expStore.push_back({addr, regs[rd]});
         end else if ((op == opBeqz && a == 0) || (op == opBnez && a != 0)) begin
            pc = pc + immv[7:0];
         end else if (op > opBnez) begin
            done = 1'b1;
            expErr = (op != opHalt);
         end
         if (wr && rd != 0) begin
            regs[rd] = v;
            expRetire.push_back({rd, v});
         end
      end
   endtask

   initial begin
      testsRun = 0;
      testsFailed = 0;
      testErrors = 0;
      runPrev = 1'b0;
   end

   always @(posedge clk) begin
      if (imemWe) begin
         prog[imemAddr] = imemData;
      end
      if (rstN && run && !runPrev) begin
         testErrors = 0;
         buildModel();
      end
      runPrev = run;
      if (rstN && retireValid) begin
         if (expRetire.size() == 0) begin
            $display("test %0d: extra retire of r%0d at %0t", testNum, retireReg, $time);
            testErrors++;
         end else if (expRetire[0] != {retireReg, retireData}) begin
            $display("Mismatch at %0t: retire r%0d = %h, expected r%0d = %h", $time,
                     retireReg, retireData, expRetire[0][18:16], expRetire[0][15:0]);
            testErrors++;
            void'(expRetire.pop_front());
         end else begin
            void'(expRetire.pop_front());
         end
      end
      if (rstN && storeValid) begin
         if (expStore.size() == 0) begin
            $display("test %0d: extra store to %h at %0t", testNum, storeAddr, $time);
            testErrors++;
         end else if (expStore[0] != {storeAddr, storeData}) begin
            $display("Mismatch at %0t: store [%h] = %h, expected [%h] = %h", $time,
                     storeAddr, storeData, expStore[0][23:16], expStore[0][15:0]);
            testErrors++;
            void'(expStore.pop_front());
         end else begin
            void'(expStore.pop_front());
         end
      end
      if (testEnd) begin
         if (testAbort) begin
            // run was cut short by a reset
            if (halted || err) begin
               $display("Mismatch at %0t: halted %b err %b after reset, expected 0 and 0",
                        $time, halted, err);
               testErrors++;
            end
         end else begin
            if (expRetire.size() != 0 || expStore.size() != 0) begin
               $display("test %0d: %0d retires and %0d stores never appeared", testNum,
                        expRetire.size(), expStore.size());
               testErrors++;
            end
            if (!halted || err != expErr) begin
               $display("Mismatch at %0t: halted %b err %b, expected halted 1 err %b", $time,
                        halted, err, expErr);
               testErrors++;
            end
         end
         testsRun++;
         if (testErrors > 0) begin
            testsFailed++;
         end
         $display("test %0d %s (%0d errors)", testNum, (testErrors > 0) ? "failed" : "passed",
                  testErrors);
      end
   end

endmodule

/* verif/procTb.sv */
// testbench top: clock, reset, random program generation, program loading and test sequence
`timescale 1ns/1ps
module procTb;
   import procPkg::*;

   logic        clk, rstN, run, imemWe, testEnd, testAbort;
   logic [7:0]  imemAddr;
   logic [15:0] imemData;
   logic        retireValid, storeValid, halted, err;
   logic [2:0]  retireReg;
   logic [15:0] retireData, storeData;
   logic [7:0]  storeAddr;
   logic [15:0] prog [memDepth];
   int          progLen, testNum, testsRun, testsFailed;

   proc DUT (.*);

   procChecker procCheck (.*);

   function automatic logic [15:0] encR(input logic [3:0] op, input logic [2:0] rd,
                                        input logic [2:0] rs, input logic [2:0] rt);
      return {op, rd, rs, rt, 3'b000};
   endfunction

   function automatic logic [15:0] encI(input logic [3:0] op, input logic [2:0] rd,
                                        input logic [2:0] rs, input logic [5:0] imm);
      return {op, rd, rs, imm};
   endfunction

   task automatic addWord(input logic [15:0] w);
      prog[progLen] = w;
      progLen++;
   endtask

   // every program sets r1..r7 first, then a body shaped by kind, then HALT
   task automatic genProgram(input int kind);
      logic [2:0] rd, rs, lastRd;
      logic [5:0] a;
      logic [5:0] stored [$];
      progLen = 0;
      lastRd = 3'd1;
      for (int i = 1; i < 8; i++) begin
         addWord(encI(opAddi, 3'(i), 3'd0, 6'($urandom)));
      end
      for (int n = 0; n < 24; n++) begin
         rd = 3'($urandom);
         rs = ($urandom % 2) ? lastRd : 3'($urandom);
         if (kind == 2 && $urandom % 2) begin
            a = 6'($urandom);
            addWord(encI(opSt, rd, 3'd0, a));
            stored.push_back(a);
         end else if (kind == 2 && stored.size() > 0) begin
            // load and its use back to back
            addWord(encI(opLd, rd, 3'd0, stored[$urandom % stored.size()]));
            addWord(encR(opAdd, 3'($urandom), rd, rd));
         end else if (kind == 3 && (n % 4 == 1 || $urandom % 3 == 0)) begin
            // odd n gives BEQZ, r0 as source for n % 4 of 0 or 1
            addWord(encI((n % 2) ? opBeqz : opBnez, 3'd0, (n % 4 <= 1) ? 3'd0 : rs,
                         6'(1 + $urandom % 3)));
         end else if (kind == 4) begin
            addWord(encR(opAdd, 3'd0, rs, rs));
            addWord(encR(opXor, rd, 3'd0, rs));
         end else if (kind == 5 && n == 5) begin
            addWord({4'(9 + $urandom % 6), 12'($urandom)});
         end
         if ($urandom % 2) begin
            addWord(encR(4'($urandom % 4), rd, rs, 3'($urandom)));
         end else begin
            addWord(encI(opAddi, rd, rs, 6'($urandom)));
         end
         lastRd = rd;
      end
      // keeps every branch target inside the program
      for (int i = 0; i < 3; i++) begin
         addWord(encR(opAdd, 3'($urandom), 3'($urandom), 3'($urandom)));
      end
      addWord(encR(opHalt, 3'd0, 3'd0, 3'd0));
   endtask

   task automatic resetDut();
      @(negedge clk);
      run = 1'b0;
      rstN = 1'b0;
      repeat (2) @(negedge clk);
      rstN = 1'b1;
   endtask

   task automatic loadProgram();
      for (int i = 0; i < progLen; i++) begin
         @(negedge clk);
         imemWe = 1'b1;
         imemAddr = 8'(i);
         imemData = prog[i];
      end
      @(negedge clk);
      imemWe = 1'b0;
      run = 1'b1;
   endtask

   task automatic endTest(input logic abort);
      @(negedge clk);
      testAbort = abort;
      testEnd = 1'b1;
      @(negedge clk);
      testEnd = 1'b0;
   endtask

   task automatic runTest(input int num, input int kind);
      int cyc;
      testNum = num;
      genProgram(kind);
      loadProgram();
      for (cyc = 0; cyc < 2000 && !halted; cyc++) begin
         @(negedge clk);
      end
      if (!halted) begin
         $display("timeout: halted never rose in test %0d", num);
         $display("SOME TESTS FAILED");
         $finish;
      end else begin
         repeat (2) @(negedge clk);
         endTest(1'b0);
         resetDut();
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      rstN = 1'b0;
      run = 1'b0;
      imemWe = 1'b0;
      imemAddr = '0;
      imemData = '0;
      testEnd = 1'b0;
      testAbort = 1'b0;
      testNum = 0;
      void'($urandom(32'h9e3811c1));
      resetDut();
      for (int t = 1; t <= 5; t++) begin
         runTest(t, t);
      end
      // stop a running program partway through
      testNum = 6;
      genProgram(1);
      loadProgram();
      repeat (12) @(negedge clk);
      resetDut();
      endTest(1'b1);
      runTest(6, 2);
      $display("tests run %0d, failed %0d", testsRun, testsFailed);
      if (testsFailed == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* filelist.f */
source/procPkg.sv
source/fetch.sv
source/decode.sv
source/execute.sv
source/memory.sv
source/proc.sv
verif/procChecker.sv
verif/procTb.sv
